//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fpDivSqrtTb
FILELIST  ?= fpDivSqrtUnit.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- fpDivSqrtUnit.f
+incdir+hw
+incdir+test
hw/fpDivSqrtPkg.sv
hw/fpIssueSel.sv
hw/fpDivSqrtLane.sv
hw/fpResultArb.sv
hw/fpDivSqrtUnit.sv
test/fpDivSqrtTb.sv

//--- hw/fpDivSqrtLane.sv
`timescale 1ns/1ps
`include "fpDivSqrt_consts.svh"

module fpDivSqrtLane import fpDivSqrtPkg::*; #(
  parameter type tagT = dsTagT  // carried untouched start to done
) (
  input  logic             clk,
  input  logic             arstN,
  input  logic             start,   // sample operands this edge
  input  fpOpE             op,
  input  logic [`DS_W-1:0] a,       // dividend / radicand
  input  logic [`DS_W-1:0] b,       // divisor, unused for sqrt
  input  tagT              tagIn,
  input  logic             take,    // result consumed
  output logic             free,
  output logic             done,    // held until take
  output logic [`DS_W-1:0] res,
  output fpFlagsT          flags,
  output tagT              tagOut
);

  localparam int cntW = $clog2(`DS_ITERS);
  localparam logic [cntW-1:0] lastCnt = cntW'(`DS_ITERS - 1);  // pack cycle
  localparam logic [`DS_W-1:0] qNan = 32'h7fc0_0000;

  logic            runR;   // unpack, steps or pack in progress
  logic            doneR;
  logic [cntW-1:0] cnt;    // 0 unpack, 1..25 steps, last pack

  logic [`DS_W-1:0]  aR;
  logic [`DS_W-1:0]  bR;
  fpOpE              opR;
  tagT               tagR;
  logic [26:0]       remR;        // partial remainder
  logic [24:0]       qR;          // quotient or root, msb first
  logic [25:0]       dR;          // divisor, or radicand pairs for sqrt
  logic signed [9:0] expR;        // biased, may leave 1..254
  logic              signR;
  logic              specR;       // special result bypasses recurrence
  logic [`DS_W-1:0]  specResR;
  fpFlagsT           specFlagsR;

  logic [7:0]  ea;
  logic [7:0]  eb;
  logic [22:0] ma;
  logic [22:0] mb;
  logic        aZero;
  logic        aInf;
  logic        aNan;
  logic        bZero;
  logic        bInf;
  logic        bNan;
  logic        sgnDiv;

  assign ea     = aR[30:23];
  assign eb     = bR[30:23];
  assign ma     = aR[22:0];
  assign mb     = bR[22:0];
  assign aZero  = (ea == 8'h00);  // subnormal read as zero
  assign bZero  = (eb == 8'h00);
  assign aInf   = (ea == 8'hff) && (ma == '0);
  assign bInf   = (eb == 8'hff) && (mb == '0);
  assign aNan   = (ea == 8'hff) && (ma != '0);
  assign bNan   = (eb == 8'hff) && (mb != '0);
  assign sgnDiv = aR[31] ^ bR[31];

  // special-case decision, used in the unpack cycle
  logic             specHit;
  logic [`DS_W-1:0] specVal;
  fpFlagsT          specFl;

  always_comb begin
    specHit = 1'b1;
    specVal = qNan;
    specFl  = '0;
    if (opR == opDiv) begin
      if (aNan || bNan)
        specVal = qNan;
      else if ((aZero && bZero) || (aInf && bInf))
        specFl.invalid = 1'b1;
      else if (aInf)
        specVal = {sgnDiv, 8'hff, 23'h0};
      else if (bZero) begin
        specVal          = {sgnDiv, 8'hff, 23'h0};
        specFl.divByZero = 1'b1;
      end else if (aZero || bInf)
        specVal = {sgnDiv, 31'h0};  // exact signed zero
      else
        specHit = 1'b0;
    end else begin
      if (aNan)
        specVal = qNan;
      else if (aZero)
        specVal = {aR[31], 31'h0};  // sqrt(-0) = -0
      else if (aR[31])
        specFl.invalid = 1'b1;      // negative nonzero, -inf too
      else if (aInf)
        specVal = 32'h7f80_0000;
      else
        specHit = 1'b0;
    end
  end

  logic [26:0] divSub;   // divisor aligned to remainder
  logic [26:0] sqRem;    // remainder with next radicand pair
  logic [26:0] sqTrial;  // 4*root + 1

  assign divSub  = {3'b0, dR[23:0]};
  assign sqRem   = {remR[24:0], dR[25:24]};
  assign sqTrial = {qR, 2'b01};

  // pack, at most one normalizing shift (division only)
  logic              norm;
  logic signed [9:0] packExp;
  logic [22:0]       packMant;
  logic              rough;
  logic [`DS_W-1:0]  packRes;
  fpFlagsT           packFl;

  always_comb begin
    norm     = qR[24];  // quotient >= 1
    packExp  = norm ? expR : expR - 10'sd1;
    packMant = norm ? qR[23:1] : qR[22:0];
    rough    = (norm & qR[0]) | (|remR);  // truncated bits nonzero
    packFl   = '0;
    if (specR) begin
      packRes = specResR;
      packFl  = specFlagsR;
    end else if (packExp >= 10'sd255) begin
      packRes        = {signR, 31'h7f7f_ffff};  // largest finite
      packFl.inexact = 1'b1;
    end else if (packExp <= 10'sd0) begin
      packRes        = {signR, 31'h0};  // underflow flush
      packFl.inexact = 1'b1;
    end else begin
      packRes        = {signR, packExp[7:0], packMant};
      packFl.inexact = rough;
    end
  end

  // control state
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      runR  <= 1'b0;
      doneR <= 1'b0;
      cnt   <= '0;
    end else begin
      if (start) begin
        runR <= 1'b1;
        cnt  <= '0;
      end else if (runR) begin
        cnt <= cnt + 1'b1;
        if (cnt == lastCnt) begin
          runR  <= 1'b0;
          doneR <= 1'b1;
        end
      end
      if (take)
        doneR <= 1'b0;  // free again next cycle
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start) begin
      aR   <= a;
      bR   <= b;
      opR  <= op;
      tagR <= tagIn;
    end
    if (runR && cnt == '0) begin  // unpack
      qR         <= '0;
      specR      <= specHit;
      specResR   <= specVal;
      specFlagsR <= specFl;
      if (opR == opDiv) begin
        remR  <= {3'b0, 1'b1, ma};
        dR    <= {2'b0, 1'b1, mb};
        expR  <= $signed({2'b0, ea}) - $signed({2'b0, eb}) + 10'sd127;
        signR <= sgnDiv;
      end else begin
        remR  <= '0;
        // even biased exponent means odd true exponent, pre-shift one
        dR    <= ea[0] ? {1'b0, 1'b1, ma, 1'b0} : {1'b1, ma, 2'b0};
        expR  <= ({2'b0, ea} + 10'd127) >> 1;
        signR <= aR[31];
      end
    end else if (runR && cnt == lastCnt) begin
      res   <= packRes;
      flags <= packFl;
    end else if (runR) begin
      if (opR == opDiv) begin  // restoring division step
        if (remR >= divSub) begin
          remR <= (remR - divSub) << 1;
          qR   <= {qR[23:0], 1'b1};
        end else begin
          remR <= remR << 1;
          qR   <= {qR[23:0], 1'b0};
        end
      end else begin           // restoring root step
        dR <= dR << 2;
        if (sqRem >= sqTrial) begin
          remR <= sqRem - sqTrial;
          qR   <= {qR[23:0], 1'b1};
        end else begin
          remR <= sqRem;
          qR   <= {qR[23:0], 1'b0};
        end
      end
    end
  end

  assign free   = ~runR & ~doneR;
  assign done   = doneR;
  assign tagOut = tagR;

  startWhenFree: assert property (
    @(posedge clk) disable iff (!arstN)
    start |-> free
  ) else $error("fpDivSqrtLane: start while lane occupied");

  takeWhenDone: assert property (
    @(posedge clk) disable iff (!arstN)
    take |-> done
  ) else $error("fpDivSqrtLane: take without result");

  // fixed latency, specials included
  // done is set at the pack edge, seen high one sample later
  fixedLatency: assert property (
    @(posedge clk) disable iff (!arstN)
    start |-> ##(`DS_ITERS + 1) $rose(done)
  ) else $error("fpDivSqrtLane: done off schedule");

endmodule

//--- hw/fpDivSqrtPkg.sv
`include "fpDivSqrt_consts.svh"

package fpDivSqrtPkg;

  // op select, one bit on the issue bus
  typedef enum logic {
    opDiv  = 1'b0,
    opSqrt = 1'b1
  } fpOpE;

  // per-result exception flags, also the sticky layout
  typedef struct packed {
    logic invalid;    // 0/0, inf/inf, sqrt of negative
    logic divByZero;  // finite nonzero / 0
    logic inexact;    // remainder left or flushed
  } fpFlagsT;

  // writeback destination
  typedef logic [`DS_TAG_W-1:0] dsTagT;

endpackage

//--- hw/fpDivSqrtUnit.sv
`timescale 1ns/1ps
`include "fpDivSqrt_consts.svh"

module fpDivSqrtUnit import fpDivSqrtPkg::*; (
  input  logic             clk,
  input  logic             arstN,
  input  logic             issueEn,
  input  fpOpE             issueOp,
  input  logic [`DS_W-1:0] issueA,    // dividend or radicand
  input  logic [`DS_W-1:0] issueB,    // divisor
  input  dsTagT            issueTag,
  input  logic             flagClr,
  output logic             busy,
  output logic             wbValid,
  output logic [`DS_W-1:0] wbData,
  output fpFlagsT          wbFlags,
  output dsTagT            wbTag,
  output fpFlagsT          stickyFlags
);

  logic [`DS_LANES-1:0]            laneStart;
  logic [`DS_LANES-1:0]            laneFree;
  logic [`DS_LANES-1:0]            laneDone;
  logic [`DS_LANES-1:0]            laneTake;
  logic [`DS_LANES-1:0][`DS_W-1:0] laneData;
  fpFlagsT [`DS_LANES-1:0]         laneFlags;
  dsTagT [`DS_LANES-1:0]           laneTag;

  fpIssueSel issueSel0 (
    .clk       (clk),
    .arstN     (arstN),
    .issueEn   (issueEn),
    .laneFree  (laneFree),
    .laneStart (laneStart),
    .busy      (busy)
  );

  // operands broadcast, only the started lane samples them
  for (genvar i = 0; i < `DS_LANES; i++) begin : laneGen
    fpDivSqrtLane #(
      .tagT (dsTagT)
    ) lane (
      .clk    (clk),
      .arstN  (arstN),
      .start  (laneStart[i]),
      .op     (issueOp),
      .a      (issueA),
      .b      (issueB),
      .tagIn  (issueTag),
      .take   (laneTake[i]),
      .free   (laneFree[i]),
      .done   (laneDone[i]),
      .res    (laneData[i]),
      .flags  (laneFlags[i]),
      .tagOut (laneTag[i])
    );
  end

  fpResultArb resultArb0 (
    .clk         (clk),
    .arstN       (arstN),
    .laneDone    (laneDone),
    .laneData    (laneData),
    .laneFlags   (laneFlags),
    .laneTag     (laneTag),
    .flagClr     (flagClr),
    .laneTake    (laneTake),
    .wbValid     (wbValid),
    .wbData      (wbData),
    .wbFlags     (wbFlags),
    .wbTag       (wbTag),
    .stickyFlags (stickyFlags)
  );

endmodule

//--- hw/fpDivSqrt_consts.svh
`ifndef FP_DIV_SQRT_CONSTS_SVH
`define FP_DIV_SQRT_CONSTS_SVH

// lane array size, any value >= 1
`define DS_LANES 3

// binary32 operands only
`define DS_W 32

// cycles from start to done:
// unpack, 25 recurrence steps, pack
`define DS_ITERS 27

// destination register tag
`define DS_TAG_W 6

`endif

//--- hw/fpIssueSel.sv
`timescale 1ns/1ps
`include "fpDivSqrt_consts.svh"

module fpIssueSel (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 issueEn,    // one-cycle issue strobe
  input  logic [`DS_LANES-1:0] laneFree,   // level per lane
  output logic [`DS_LANES-1:0] laneStart,  // one-hot or zero
  output logic                 busy        // no lane left
);

  // lowest free lane wins
  // scan from the top so the last hit is the lowest index
  always_comb begin
    laneStart = '0;
    for (int i = `DS_LANES - 1; i >= 0; i--) begin
      if (laneFree[i]) begin
        laneStart    = '0;
        laneStart[i] = issueEn;  // strobe only on a real issue
      end
    end
  end

  assign busy = ~|laneFree;  // every lane running or holding a result

  // at most one lane started per issue
  startOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
    $onehot0(laneStart)
  ) else $error("fpIssueSel: more than one lane started");

  // upstream must hold off while busy
  noIssueWhenBusy: assert property (
    @(posedge clk) disable iff (!arstN)
    busy |-> !issueEn
  ) else $error("fpIssueSel: issue while busy");

  // started lane must drop its free level right after the edge
  startedLaneTaken: assert property (
    @(posedge clk) disable iff (!arstN)
    |laneStart |=> ((laneFree & $past(laneStart)) == '0)
  ) else $error("fpIssueSel: started lane still free");

endmodule

//--- hw/fpResultArb.sv
`timescale 1ns/1ps
`include "fpDivSqrt_consts.svh"

module fpResultArb import fpDivSqrtPkg::*; (
  input  logic                            clk,
  input  logic                            arstN,
  input  logic [`DS_LANES-1:0]            laneDone,
  input  logic [`DS_LANES-1:0][`DS_W-1:0] laneData,
  input  fpFlagsT [`DS_LANES-1:0]         laneFlags,
  input  dsTagT [`DS_LANES-1:0]           laneTag,
  input  logic                            flagClr,
  output logic [`DS_LANES-1:0]            laneTake,
  output logic                            wbValid,
  output logic [`DS_W-1:0]                wbData,
  output fpFlagsT                         wbFlags,
  output dsTagT                           wbTag,
  output fpFlagsT                         stickyFlags
);

  logic             anyDone;
  logic [`DS_W-1:0] selData;
  fpFlagsT          selFlags;
  dsTagT            selTag;

  assign anyDone = |laneDone;

  // fixed priority, lane 0 highest
  always_comb begin
    laneTake = '0;
    selData  = '0;
    selFlags = '0;
    selTag   = '0;
    for (int i = `DS_LANES - 1; i >= 0; i--) begin
      if (laneDone[i]) begin
        laneTake    = '0;
        laneTake[i] = 1'b1;
        selData     = laneData[i];
        selFlags    = laneFlags[i];
        selTag      = laneTag[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbValid     <= 1'b0;
      stickyFlags <= '0;
    end else begin
      wbValid <= anyDone;  // one pulse per taken lane
      if (flagClr)
        stickyFlags <= anyDone ? selFlags : fpFlagsT'('0);  // clear, keep new result
      else if (anyDone)
        stickyFlags <= stickyFlags | selFlags;
    end
  end

  // writeback payload
  always_ff @(posedge clk) begin
    if (anyDone) begin
      wbData  <= selData;
      wbFlags <= selFlags;
      wbTag   <= selTag;
    end
  end

  takeOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
    $onehot0(laneTake)
  ) else $error("fpResultArb: more than one lane taken");

endmodule

//--- test/fpDivSqrtVectors.svh
`ifndef FP_DIV_SQRT_VECTORS_SVH
`define FP_DIV_SQRT_VECTORS_SVH

// columns: op, a, b, expected result, expected flags {invalid, divByZero, inexact}
// b is don't-care for sqrt
localparam int numVec = 16;

localparam vecT vecTab [numVec] = '{
  '{opDiv,  32'h40c0_0000, 32'h4000_0000, 32'h4040_0000, 3'b000},  // 6/2
  '{opDiv,  32'hbf80_0000, 32'h4080_0000, 32'hbe80_0000, 3'b000},  // -1/4
  '{opSqrt, 32'h4110_0000, 32'h0000_0000, 32'h4040_0000, 3'b000},  // sqrt 9
  '{opSqrt, 32'h3e80_0000, 32'h0000_0000, 32'h3f00_0000, 3'b000},  // sqrt 0.25
  '{opDiv,  32'h3f80_0000, 32'h4040_0000, 32'h3eaa_aaaa, 3'b001},  // 1/3 truncated
  '{opDiv,  32'h4000_0000, 32'h4040_0000, 32'h3f2a_aaaa, 3'b001},  // 2/3
  '{opSqrt, 32'h4000_0000, 32'h0000_0000, 32'h3fb5_04f3, 3'b001},  // sqrt 2
  '{opDiv,  32'h0000_0000, 32'h0000_0000, 32'h7fc0_0000, 3'b100},  // 0/0
  '{opDiv,  32'h7f80_0000, 32'h7f80_0000, 32'h7fc0_0000, 3'b100},  // inf/inf
  '{opSqrt, 32'hbf80_0000, 32'h0000_0000, 32'h7fc0_0000, 3'b100},  // sqrt -1
  '{opDiv,  32'h3f80_0000, 32'h0000_0000, 32'h7f80_0000, 3'b010},  // 1/0
  '{opSqrt, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 3'b000},  // sqrt -0 keeps sign
  '{opDiv,  32'h7fc0_0001, 32'h3f80_0000, 32'h7fc0_0000, 3'b000},  // nan in, canonical out
  '{opDiv,  32'h8040_0000, 32'h3f80_0000, 32'h8000_0000, 3'b000},  // subnormal as -0
  '{opDiv,  32'h7f7f_ffff, 32'h3f00_0000, 32'h7f7f_ffff, 3'b001},  // overflow clamps
  '{opDiv,  32'h0080_0000, 32'h4f00_0000, 32'h0000_0000, 3'b001}   // underflow flush
};

`endif

//--- test/fpDivSqrtTb.sv
`timescale 1ns/1ps
`include "fpDivSqrt_consts.svh"

module fpDivSqrtTb import fpDivSqrtPkg::*; ();

  typedef struct packed {
    fpOpE        op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;  // expected result
    fpFlagsT     fl;   // expected flags
  } vecT;

  `include "fpDivSqrtVectors.svh"

  localparam int wdCycles = (numVec + `DS_LANES) * (`DS_ITERS + 8);

  logic             clk;
  logic             arstN;
  logic             issueEn;
  fpOpE             issueOp;
  logic [`DS_W-1:0] issueA;
  logic [`DS_W-1:0] issueB;
  dsTagT            issueTag;
  logic             flagClr;
  logic             busy;
  logic             wbValid;
  logic [`DS_W-1:0] wbData;
  fpFlagsT          wbFlags;
  dsTagT            wbTag;
  fpFlagsT          stickyFlags;

  logic seen [numVec];  // tag returned already
  int   nSeen;
  logic sawBusy;        // all lanes filled at some point

  fpDivSqrtUnit dut0 (
    .clk         (clk),
    .arstN       (arstN),
    .issueEn     (issueEn),
    .issueOp     (issueOp),
    .issueA      (issueA),
    .issueB      (issueB),
    .issueTag    (issueTag),
    .flagClr     (flagClr),
    .busy        (busy),
    .wbValid     (wbValid),
    .wbData      (wbData),
    .wbFlags     (wbFlags),
    .wbTag       (wbTag),
    .stickyFlags (stickyFlags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp)
      failRun($sformatf("Error at %0t: %s = %h, expected %h", $time, name, act, exp));
  endtask

  // watchdog, sized from table length and lane latency
  initial begin
    repeat (wdCycles) @(posedge clk);
    failRun($sformatf("timeout: not all results came back within %0d cycles", wdCycles));
  end

  // writeback monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (arstN && busy)
      sawBusy = 1'b1;
    if (arstN && wbValid) begin
      if (int'(wbTag) >= numVec)
        failRun($sformatf("writeback carries tag %0d that was never issued", wbTag));
      if (seen[wbTag])
        failRun($sformatf("tag %0d written back twice", wbTag));
      check($sformatf("wbData[tag %0d]", wbTag), wbData, vecTab[wbTag].res);
      check($sformatf("wbFlags[tag %0d]", wbTag), wbFlags, vecTab[wbTag].fl);
      seen[wbTag] = 1'b1;
      nSeen++;
    end
  end

  initial begin
    int      gap;
    fpFlagsT expSticky;
    void'($urandom(32'hbd3c_ec7b));
    arstN     = 1'b0;
    issueEn   = 1'b0;
    issueOp   = opDiv;
    issueA    = '0;
    issueB    = '0;
    issueTag  = '0;
    flagClr   = 1'b0;
    nSeen     = 0;
    sawBusy   = 1'b0;
    expSticky = '0;
    for (int i = 0; i < numVec; i++)
      seen[i] = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    for (int i = 0; i < numVec; i++) begin
      gap = (i < `DS_LANES) ? 0 : int'($urandom % 4);  // first lanes back to back
      repeat (gap) @(negedge clk);
      while (busy)
        @(negedge clk);
      issueEn   = 1'b1;
      issueOp   = vecTab[i].op;
      issueA    = vecTab[i].a;
      issueB    = vecTab[i].b;
      issueTag  = dsTagT'(i);  // tag = table index
      expSticky = fpFlagsT'(expSticky | vecTab[i].fl);
      @(negedge clk);
      issueEn = 1'b0;
    end

    wait (nSeen == numVec);
    @(negedge clk);
    check("stickyFlags", stickyFlags, expSticky);
    check("busy seen high", sawBusy, 1'b1);

    // clear with no writeback pending
    check("wbValid during flagClr", wbValid, 1'b0);
    flagClr = 1'b1;
    @(negedge clk);
    flagClr = 1'b0;
    check("stickyFlags after flagClr", stickyFlags, '0);

    $display("Test OK");
    $finish;
  end

endmodule
